//--- revo_pkg.sv
package revo_pkg;

	// ------------------------------
	// frame ring and word kinds
	// ------------------------------

	// four-cycle frame of the sampler, in ring order
	typedef enum logic [1:0] {
		PHASE_LATCH,
		PHASE_REDUCE,
		PHASE_ARM,
		PHASE_VETO
	} phase_t;

	// one entry of the trigger word FIFO
	typedef enum logic {
		WORD_NULL,
		WORD_TRG
	} word_kind_t;

	// ------------------------------
	// line format
	// ------------------------------

	// serial patterns, sent msb first
	localparam logic [7:0] WORD_NULL_PATTERN = 8'b11000000;
	localparam logic [7:0] WORD_TRG_PATTERN = 8'b00111111;

	// four 509 MHz samples per 127 MHz period
	localparam int SAMPLES_PER_CYCLE = 4;

	// serial bits sent per clock127 cycle
	localparam int BITS_PER_CYCLE = 2;

endpackage

//--- revo_stream_sampler.sv
`timescale 1ns/1ps

module revo_stream_sampler import revo_pkg::*; #(
	parameter int TRGSTREAM_WIDTH = 16,
	parameter int TRG_MAX_DURATION = 8
) (
	input  logic clock127,
	input  logic reset,
	input  logic [SAMPLES_PER_CYCLE-1:0] revo_samples,
	output logic push,
	output word_kind_t push_kind,
	output logic trg_level
);

	localparam int UPPER_WIDTH = TRGSTREAM_WIDTH - TRG_MAX_DURATION;

	// sliding window, newest samples at the low end
	logic [TRGSTREAM_WIDTH-1:0] window;

	phase_t phase;
	phase_t next_phase;

	// split of the window latched at the start of a frame
	logic [UPPER_WIDTH-1:0] upper;
	logic [TRG_MAX_DURATION-1:0] lower;
	logic upper_any;
	logic lower_any;

	// decision being built for the current frame
	logic should_trg;

	// set once the first full frame has been evaluated
	logic primed;

	// ------------------------------
	// sample window
	// ------------------------------

	// revo_samples[3] is the oldest of the four, so it lands highest
	always_ff @(posedge clock127) begin
		if (reset) begin
			window <= '0;
		end else begin
			window <= {window[TRGSTREAM_WIDTH-SAMPLES_PER_CYCLE-1:0], revo_samples};
		end
	end

	// ------------------------------
	// frame ring
	// ------------------------------

	always_comb begin
		case (phase)
			PHASE_LATCH: next_phase = PHASE_REDUCE;
			PHASE_REDUCE: next_phase = PHASE_ARM;
			PHASE_ARM: next_phase = PHASE_VETO;
			default: next_phase = PHASE_LATCH;
		endcase
	end

	always_ff @(posedge clock127) begin
		if (reset) begin
			phase <= PHASE_LATCH;
			primed <= 1'b0;
		end else begin
			phase <= next_phase;
			if (phase == PHASE_VETO) begin
				primed <= 1'b1;
			end
		end
	end

	// ------------------------------
	// split and reduce
	// ------------------------------

	always_ff @(posedge clock127) begin
		if (phase == PHASE_LATCH) begin
			upper <= window[TRGSTREAM_WIDTH-1:TRG_MAX_DURATION];
			lower <= window[TRG_MAX_DURATION-1:0];
		end
		if (phase == PHASE_REDUCE) begin
			upper_any <= |upper;
			lower_any <= |lower;
		end
	end

	// ------------------------------
	// arm then veto
	// ------------------------------

	// pulse in the newest part arms, any activity in the older part vetoes
	always_ff @(posedge clock127) begin
		if (reset) begin
			should_trg <= 1'b0;
			trg_level <= 1'b0;
		end else begin
			case (phase)
				PHASE_LATCH: begin
					if (primed) begin
						trg_level <= should_trg;
					end
				end
				PHASE_REDUCE: begin
					should_trg <= 1'b0;
				end
				PHASE_ARM: begin
					if (lower_any) begin
						should_trg <= 1'b1;
					end
				end
				default: begin
					if (upper_any) begin
						should_trg <= 1'b0;
					end
				end
			endcase
		end
	end

	// the finished decision is handed over as the next frame opens
	assign push = primed && (phase == PHASE_LATCH);
	assign push_kind = should_trg ? WORD_TRG : WORD_NULL;

	// a push opens a frame and carries the arm then veto result of the last one
	push_matches_rule: assert property (
		@(posedge clock127) disable iff (reset)
		push |-> (phase == PHASE_LATCH)
			&& ((push_kind == WORD_TRG) == (lower_any && !upper_any))
	);

endmodule

//--- trigger_word_fifo.sv
`timescale 1ns/1ps

module trigger_word_fifo import revo_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic clock127,
	input  logic reset,
	input  logic push,
	input  word_kind_t push_kind,
	input  logic pop,
	output logic empty,
	output word_kind_t head_kind,
	output logic overflow
);

	localparam int ADDR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [ADDR_WIDTH:0] FULL_COUNT = (ADDR_WIDTH+1)'(FIFO_DEPTH);

	word_kind_t storage [FIFO_DEPTH];

	logic [ADDR_WIDTH-1:0] write_ptr;
	logic [ADDR_WIDTH-1:0] read_ptr;
	logic [ADDR_WIDTH:0] count;

	logic full;
	logic take;
	logic accept;

	// ------------------------------
	// status and head
	// ------------------------------

	assign full = (count == FULL_COUNT);
	assign empty = (count == '0);

	// show-ahead, the head entry is on the output whenever not empty
	assign head_kind = storage[read_ptr];

	assign take = pop && !empty;

	// a full FIFO still takes a push when the head leaves in the same cycle
	assign accept = push && (!full || take);

	// ------------------------------
	// storage
	// ------------------------------

	always_ff @(posedge clock127) begin
		if (accept) begin
			storage[write_ptr] <= push_kind;
		end
	end

	// ------------------------------
	// pointers, count, overflow
	// ------------------------------

	// depth is a power of two so the pointers simply wrap
	always_ff @(posedge clock127) begin
		if (reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (accept) begin
				write_ptr <= write_ptr + 1'b1;
			end
			if (take) begin
				read_ptr <= read_ptr + 1'b1;
			end
			case ({accept, take})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// dropped push, held until reset
			if (push && !accept) begin
				overflow <= 1'b1;
			end
		end
	end

	// the serializer must only pop a word that is really there
	no_pop_when_empty: assert property (
		@(posedge clock127) disable iff (reset)
		pop |-> !empty
	);

endmodule

//--- word_serializer.sv
`timescale 1ns/1ps

module word_serializer import revo_pkg::*; (
	input  logic clock127,
	input  logic reset,
	input  logic empty,
	input  word_kind_t head_kind,
	output logic pop,
	output logic [BITS_PER_CYCLE-1:0] serial_data,
	output logic serial_valid,
	output logic word_start,
	output logic trg_enable_n
);

	localparam int WORD_BITS = $bits(WORD_NULL_PATTERN);
	localparam int PAIRS_PER_WORD = WORD_BITS / BITS_PER_CYCLE;
	localparam int PAIR_WIDTH = $clog2(PAIRS_PER_WORD);
	localparam logic [PAIR_WIDTH-1:0] LAST_PAIR = PAIR_WIDTH'(PAIRS_PER_WORD - 1);

	logic busy;
	logic [PAIR_WIDTH-1:0] pair_count;
	logic last_pair;

	// word on the line and its kind
	logic [WORD_BITS-1:0] shift_reg;
	word_kind_t word_kind;
	logic [WORD_BITS-1:0] next_pattern;

	// ------------------------------
	// pop and pattern select
	// ------------------------------

	assign last_pair = busy && (pair_count == LAST_PAIR);

	// back to back words when the FIFO keeps up
	assign pop = !empty && (!busy || last_pair);

	assign next_pattern = (head_kind == WORD_TRG) ? WORD_TRG_PATTERN : WORD_NULL_PATTERN;

	// ------------------------------
	// pair counter
	// ------------------------------

	always_ff @(posedge clock127) begin
		if (reset) begin
			busy <= 1'b0;
			pair_count <= '0;
		end else if (pop) begin
			busy <= 1'b1;
			pair_count <= '0;
		end else if (last_pair) begin
			busy <= 1'b0;
		end else if (busy) begin
			pair_count <= pair_count + 1'b1;
		end
	end

	// ------------------------------
	// shift register
	// ------------------------------

	always_ff @(posedge clock127) begin
		if (pop) begin
			shift_reg <= next_pattern;
			word_kind <= head_kind;
		end else begin
			shift_reg <= shift_reg << BITS_PER_CYCLE;
		end
	end

	// msb pair first, line held low between words
	assign serial_data = busy ? shift_reg[WORD_BITS-1 -: BITS_PER_CYCLE] : '0;
	assign serial_valid = busy;
	assign word_start = busy && (pair_count == '0);

	// active-low strobe over all four cycles of a trigger word
	assign trg_enable_n = !(busy && (word_kind == WORD_TRG));

	// a word is never cut short by an early pop
	pop_at_word_boundary: assert property (
		@(posedge clock127) disable iff (reset)
		word_start |=> (serial_valid && !word_start) ##1 (serial_valid && !word_start)
			##1 (serial_valid && !word_start)
	);

endmodule

//--- revo_encoder_top.sv
`timescale 1ns/1ps

module revo_encoder_top import revo_pkg::*; #(
	parameter int TRGSTREAM_WIDTH = 16,
	parameter int TRG_MAX_DURATION = 8,
	parameter int FIFO_DEPTH = 4
) (
	input  logic clock127,
	input  logic reset,
	input  logic [SAMPLES_PER_CYCLE-1:0] revo_samples,
	output logic [BITS_PER_CYCLE-1:0] serial_data,
	output logic serial_valid,
	output logic word_start,
	output logic trg_enable_n,
	output logic trg_level,
	output logic overflow
);

	// sampler to FIFO
	logic push;
	word_kind_t push_kind;

	// FIFO to serializer and back
	logic pop;
	logic empty;
	word_kind_t head_kind;

	// ------------------------------
	// producer, buffer, consumer
	// ------------------------------

	revo_stream_sampler #(
		.TRGSTREAM_WIDTH(TRGSTREAM_WIDTH),
		.TRG_MAX_DURATION(TRG_MAX_DURATION)
	) sampler (
		.clock127(clock127),
		.reset(reset),
		.revo_samples(revo_samples),
		.push(push),
		.push_kind(push_kind),
		.trg_level(trg_level)
	);

	trigger_word_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) word_fifo (
		.clock127(clock127),
		.reset(reset),
		.push(push),
		.push_kind(push_kind),
		.pop(pop),
		.empty(empty),
		.head_kind(head_kind),
		.overflow(overflow)
	);

	word_serializer serializer (
		.clock127(clock127),
		.reset(reset),
		.empty(empty),
		.head_kind(head_kind),
		.pop(pop),
		.serial_data(serial_data),
		.serial_valid(serial_valid),
		.word_start(word_start),
		.trg_enable_n(trg_enable_n)
	);

endmodule

//--- revo_encoder_tb.sv
`timescale 1ns/1ps

module revo_encoder_tb import revo_pkg::*; ();

	localparam int TRGSTREAM_WIDTH = 16;
	localparam int TRG_MAX_DURATION = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int CLOCK_PERIOD = 10;

	localparam int RESET_CYCLES = 2;
	localparam int IDLE_CYCLES = 40 * 4;
	localparam int PULSE_CYCLES = 12;
	localparam int PULSE_COUNT = 12;
	localparam int RANDOM_CYCLES = 400;
	localparam int DRAIN_CYCLES = 12;
	localparam int STIM_CYCLES = RESET_CYCLES + IDLE_CYCLES + PULSE_CYCLES * PULSE_COUNT
		+ RANDOM_CYCLES + DRAIN_CYCLES;

	logic clock127;
	logic reset;
	logic [SAMPLES_PER_CYCLE-1:0] revo_samples;
	logic [BITS_PER_CYCLE-1:0] serial_data;
	logic serial_valid;
	logic word_start;
	logic trg_enable_n;
	logic trg_level;
	logic overflow;

	int state_errors = 0;
	int word_errors = 0;
	int end_errors = 0;
	int words_checked = 0;
	logic [15:0] lfsr_state;

	// reference window and expected words
	logic [TRGSTREAM_WIDTH-1:0] ref_window;
	int ref_cycle = 0;
	logic reset_seen = 1'b0;
	logic [7:0] expected_words [$];

	// decision of the last latch and the one shown on trg_level
	logic pending_level = 1'b0;
	logic held_level = 1'b0;

	// word assembly on the serial side
	int pair_index = 0;
	int compare_cycle = 0;
	int last_start_cycle = -1;
	logic [7:0] received_word;
	logic [3:0] enable_bits;
	logic [3:0] valid_bits;

	revo_encoder_top #(
		.TRGSTREAM_WIDTH(TRGSTREAM_WIDTH),
		.TRG_MAX_DURATION(TRG_MAX_DURATION),
		.FIFO_DEPTH(FIFO_DEPTH)
	) UUT (
		.clock127(clock127),
		.reset(reset),
		.revo_samples(revo_samples),
		.serial_data(serial_data),
		.serial_valid(serial_valid),
		.word_start(word_start),
		.trg_enable_n(trg_enable_n),
		.trg_level(trg_level),
		.overflow(overflow)
	);

	initial begin
		clock127 = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2) clock127 = ~clock127;
		end
	end

	// ------------------------------
	// reference model
	// ------------------------------

	// trigger only on a pulse in the newest part with a quiet older part
	function automatic logic [7:0] expected_pattern(input logic [TRGSTREAM_WIDTH-1:0] latched);
		logic [TRGSTREAM_WIDTH-TRG_MAX_DURATION-1:0] older;
		logic [TRG_MAX_DURATION-1:0] newest;
		older = latched[TRGSTREAM_WIDTH-1:TRG_MAX_DURATION];
		newest = latched[TRG_MAX_DURATION-1:0];
		if (newest != '0 && older == '0) begin
			return WORD_TRG_PATTERN;
		end
		return WORD_NULL_PATTERN;
	endfunction

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	task automatic take_random_bit(output logic bit_out);
		bit_out = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
	endtask

	always @(posedge clock127) begin
		logic [7:0] latched_pattern;
		// quiet outputs during reset and until the first word is on the line
		if ((reset && reset_seen) || (!reset && ref_cycle < 5)) begin
			assert (!serial_valid && !word_start && !overflow && trg_enable_n && !trg_level)
			else begin
				state_errors++;
				$display("mismatch at %0t: reset state valid=%b start=%b ovf=%b en_n=%b lvl=%b",
					$time, serial_valid, word_start, overflow, trg_enable_n, trg_level);
			end
		end
		if (reset) begin
			reset_seen = 1'b1;
			ref_window = '0;
			ref_cycle = 0;
			pending_level = 1'b0;
			held_level = 1'b0;
		end else begin
			assert (!overflow) else begin
				state_errors++;
				$display("mismatch at %0t: overflow expected 0, received 1", $time);
			end
			// trg_level shows the decision pushed as the current frame opened
			assert (trg_level == held_level) else begin
				state_errors++;
				$display("mismatch at %0t: trg_level expected %b, received %b",
					$time, held_level, trg_level);
			end
			if (ref_cycle % 4 == 0) begin
				latched_pattern = expected_pattern(ref_window);
				expected_words.push_back(latched_pattern);
				held_level = pending_level;
				pending_level = (latched_pattern == WORD_TRG_PATTERN);
			end
			ref_window = {ref_window[TRGSTREAM_WIDTH-SAMPLES_PER_CYCLE-1:0], revo_samples};
			ref_cycle++;
		end
	end

	// ------------------------------
	// compare
	// ------------------------------

	always @(posedge clock127) begin
		logic [7:0] expected;
		logic [3:0] expected_enable;
		if (!reset) begin
			compare_cycle++;
			if (word_start) begin
				assert (pair_index == 0) else begin
					word_errors++;
					$display("word_start at %0t arrived in the middle of a word", $time);
				end
				if (last_start_cycle >= 0) begin
					assert (compare_cycle - last_start_cycle == 4) else begin
						word_errors++;
						$display("mismatch at %0t: word_start spacing expected 4, received %0d",
							$time, compare_cycle - last_start_cycle);
					end
				end
				last_start_cycle = compare_cycle;
				pair_index = 0;
			end
			if (word_start || pair_index > 0) begin
				received_word = {received_word[5:0], serial_data};
				enable_bits = {enable_bits[2:0], trg_enable_n};
				valid_bits = {valid_bits[2:0], serial_valid};
				pair_index++;
				if (pair_index == 4) begin
					pair_index = 0;
					words_checked++;
					if (expected_words.size() == 0) begin
						word_errors++;
						$display("word %b at %0t came with no expected word left",
							received_word, $time);
					end else begin
						expected = expected_words.pop_front();
						expected_enable = (expected == WORD_TRG_PATTERN) ? 4'b0000 : 4'b1111;
						assert (received_word == expected) else begin
							word_errors++;
							$display("mismatch at %0t: word expected %b, received %b",
								$time, expected, received_word);
						end
						assert (enable_bits == expected_enable) else begin
							word_errors++;
							$display("mismatch at %0t: trg_enable_n expected %b, received %b",
								$time, expected_enable, enable_bits);
						end
						assert (valid_bits == 4'b1111) else begin
							word_errors++;
							$display("mismatch at %0t: serial_valid expected 1111, received %b",
								$time, valid_bits);
						end
					end
				end
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------

	task automatic drive_cycle(input logic [SAMPLES_PER_CYCLE-1:0] samples);
		@(posedge clock127);
		#1;
		revo_samples = samples;
	endtask

	// slot 0 is the oldest sample of a cycle and goes to bit 3
	task automatic drive_pulse(input int lead, input int length);
		logic [SAMPLES_PER_CYCLE-1:0] samples;
		int index;
		for (int cycle = 0; cycle < PULSE_CYCLES; cycle++) begin
			for (int slot = 0; slot < SAMPLES_PER_CYCLE; slot++) begin
				index = cycle * SAMPLES_PER_CYCLE + slot;
				samples[SAMPLES_PER_CYCLE-1-slot] = (index >= lead) && (index < lead + length);
			end
			drive_cycle(samples);
		end
	endtask

	// sparse and dense stretches of 50 cycles take turns
	task automatic drive_random(input int cycles);
		logic [SAMPLES_PER_CYCLE-1:0] samples;
		logic sample;
		logic extra;
		for (int cycle = 0; cycle < cycles; cycle++) begin
			for (int slot = 0; slot < SAMPLES_PER_CYCLE; slot++) begin
				take_random_bit(sample);
				if ((cycle / 50) % 2 == 0) begin
					for (int k = 0; k < 3; k++) begin
						take_random_bit(extra);
						sample = sample & extra;
					end
				end
				samples[SAMPLES_PER_CYCLE-1-slot] = sample;
			end
			drive_cycle(samples);
		end
	endtask

	task automatic wait_for_checked_word();
		int start_count;
		start_count = words_checked;
		while (words_checked == start_count) begin
			@(posedge clock127);
			#1;
		end
	endtask

	initial begin
		revo_samples = '0;
		reset = 1'b1;
		lfsr_state = 16'd57404;
		repeat (RESET_CYCLES) @(posedge clock127);
		#1;
		reset = 1'b0;
		repeat (IDLE_CYCLES) drive_cycle('0);
		// short pulses, start moved across the frame and inside the cycle
		for (int length = 1; length <= TRG_MAX_DURATION; length++) begin
			drive_pulse(3 * length, length);
		end
		// long pulses end up vetoed
		drive_pulse(1, 9);
		drive_pulse(2, 12);
		drive_pulse(0, 20);
		drive_pulse(3, 30);
		drive_random(RANDOM_CYCLES);
		drive_cycle('0);
		wait_for_checked_word();
		assert (expected_words.size() <= 2) else begin
			end_errors++;
			$display("%0d expected words were never received", expected_words.size());
		end
		assert (words_checked >= (STIM_CYCLES - RESET_CYCLES - DRAIN_CYCLES) / 4 - 3) else begin
			end_errors++;
			$display("only %0d words were received", words_checked);
		end
		$display("summary: %0d words checked, %0d state errors, %0d word errors, %0d end errors",
			words_checked, state_errors, word_errors, end_errors);
		if (state_errors + word_errors + end_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#((STIM_CYCLES + 50) * CLOCK_PERIOD);
		$display("watchdog fired, the run did not finish within %0d cycles", STIM_CYCLES + 50);
		$display("summary: %0d words checked, %0d state errors, %0d word errors, %0d end errors",
			words_checked, state_errors, word_errors, end_errors);
		$display("test failed");
		$finish;
	end

endmodule

//--- project.f
revo_pkg.sv
revo_stream_sampler.sv
trigger_word_fifo.sv
word_serializer.sv
revo_encoder_top.sv
revo_encoder_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the revo encoder testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
	--top-module revo_encoder_tb -o revo_sim

output=$(./obj_dir/revo_sim)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
	exit 0
else
	exit 1
fi
